/* src/dcache_pkg.sv */
package dcache_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////
  localparam int data_bits        = 64;
  localparam int addr_bits        = 32;
  localparam int offset_bits      = 3;
  localparam int index_bits       = 5;
  localparam int num_lines        = 32;
  localparam int tag_bits         = 24;
  localparam int miss_queue_depth = 4;

  // tag in the upper bits, index below it
  typedef logic [tag_bits+index_bits-1:0] line_addr_t;

  ////////////////////////////////////////
  // processor side
  ////////////////////////////////////////
  typedef struct packed {
    logic                 en;
    logic [addr_bits-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic                 en;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic                 valid;
    logic [data_bits-1:0] data;
  } rd_result_t;

  typedef struct packed {
    logic                 valid;
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] data;
  } miss_result_t;

  ////////////////////////////////////////
  // cache storage
  ////////////////////////////////////////
  typedef struct packed {
    logic                  en;
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic [data_bits-1:0]  data;
  } cache_write_t;

  typedef struct packed {
    logic                 valid;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

endpackage

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int mem_tag_bits = 4;

  typedef enum logic [1:0] {
    bus_none = 2'd0,
    bus_load = 2'd1
  } mem_command_t;

  typedef struct packed {
    mem_command_t                     command;
    logic [dcache_pkg::addr_bits-1:0] addr;
  } mem_req_t;

  // resp_tag of zero means the command was not taken,
  // data_tag of zero means no data this cycle
  typedef struct packed {
    logic [mem_tag_bits-1:0]          resp_tag;
    logic [dcache_pkg::data_bits-1:0] data;
    logic [mem_tag_bits-1:0]          data_tag;
  } mem_resp_t;

endpackage

/* src/request_decode.sv */
`timescale 1ns/1ps

module request_decode (
  input  dcache_pkg::rd_req_t                rd_req,
  input  dcache_pkg::wr_req_t                wr_req,
  input  dcache_pkg::cache_line_t            lookup_line,
  output logic [dcache_pkg::index_bits-1:0]  lookup_index,
  output dcache_pkg::rd_result_t             rd_result,
  output logic                               miss_alloc_valid,
  output dcache_pkg::line_addr_t             miss_alloc_line,
  output logic                               store_valid,
  output dcache_pkg::line_addr_t             store_line,
  output dcache_pkg::cache_write_t           store_write
);

  logic [dcache_pkg::tag_bits-1:0] rd_tag;
  logic                            hit;

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////
  assign rd_tag       = rd_req.addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign lookup_index = rd_req.addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];

  assign hit = rd_req.en && lookup_line.valid && (lookup_line.tag == rd_tag);

  assign rd_result.valid = hit;
  assign rd_result.data  = lookup_line.data;

  // misses go to the queue, which merges or drops them
  assign miss_alloc_valid = rd_req.en && !hit;
  assign miss_alloc_line  =
    rd_req.addr[dcache_pkg::offset_bits +: dcache_pkg::tag_bits + dcache_pkg::index_bits];

  ////////////////////////////////////////
  // store path
  ////////////////////////////////////////
  assign store_valid = wr_req.en;
  assign store_line  =
    wr_req.addr[dcache_pkg::offset_bits +: dcache_pkg::tag_bits + dcache_pkg::index_bits];

  // whole word per line, so a store always allocates
  assign store_write.en    = wr_req.en;
  assign store_write.index = wr_req.addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign store_write.tag   = wr_req.addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign store_write.data  = wr_req.data;

endmodule

/* src/cache_array.sv */
`timescale 1ns/1ps

module cache_array (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [dcache_pkg::index_bits-1:0] lookup_index,
  input  dcache_pkg::cache_write_t          fill_write,
  input  dcache_pkg::cache_write_t          store_write,
  output dcache_pkg::cache_line_t           lookup_line
);

  logic [dcache_pkg::num_lines-1:0] valid_q;
  logic [dcache_pkg::tag_bits-1:0]  tag_q  [dcache_pkg::num_lines];
  logic [dcache_pkg::data_bits-1:0] data_q [dcache_pkg::num_lines];

  ////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (fill_write.en) begin
        valid_q[fill_write.index] <= 1'b1;
      end
      if (store_write.en) begin
        valid_q[store_write.index] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // tag and data
  ////////////////////////////////////////
  // store comes second so it wins on a shared index
  always_ff @(posedge clock) begin
    if (fill_write.en) begin
      tag_q[fill_write.index]  <= fill_write.tag;
      data_q[fill_write.index] <= fill_write.data;
    end
    if (store_write.en) begin
      tag_q[store_write.index]  <= store_write.tag;
      data_q[store_write.index] <= store_write.data;
    end
  end

  // current contents, no read latency
  assign lookup_line.valid = valid_q[lookup_index];
  assign lookup_line.tag   = tag_q[lookup_index];
  assign lookup_line.data  = data_q[lookup_index];

endmodule

/* src/miss_queue.sv */
`timescale 1ns/1ps

module miss_queue (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             miss_alloc_valid,
  input  dcache_pkg::line_addr_t           miss_alloc_line,
  input  logic                             store_valid,
  input  dcache_pkg::line_addr_t           store_line,
  input  mem_bus_pkg::mem_resp_t           mem_resp,
  output mem_bus_pkg::mem_req_t            mem_req,
  output logic                             fill_valid,
  output dcache_pkg::line_addr_t           fill_line,
  output logic                             fill_write_cache,
  output logic [dcache_pkg::data_bits-1:0] fill_data
);

  // one extra pointer bit tells full from empty
  typedef logic [$clog2(dcache_pkg::miss_queue_depth):0]   ptr_t;
  typedef logic [$clog2(dcache_pkg::miss_queue_depth)-1:0] slot_t;

  typedef struct packed {
    dcache_pkg::line_addr_t               line;
    logic [mem_bus_pkg::mem_tag_bits-1:0] mem_tag;
    logic                                 sent;
    logic                                 write_cache;
  } entry_t;

  entry_t                                 entries [dcache_pkg::miss_queue_depth];
  logic [dcache_pkg::miss_queue_depth-1:0] entry_valid;
  logic [dcache_pkg::miss_queue_depth-1:0] store_match;

  ptr_t  tail_ptr, send_ptr, wait_ptr;
  slot_t tail_slot, send_slot, wait_slot;
  logic  queue_full, have_unsent, merge_hit;
  logic  alloc, accepted, retire;

  assign tail_slot = slot_t'(tail_ptr);
  assign send_slot = slot_t'(send_ptr);
  assign wait_slot = slot_t'(wait_ptr);

  ////////////////////////////////////////
  // line match against live entries
  ////////////////////////////////////////
  always_comb begin
    merge_hit = 1'b0;
    for (int i = 0; i < dcache_pkg::miss_queue_depth; i++) begin
      store_match[i] = store_valid && entry_valid[i] && (entries[i].line == store_line);
      if (entry_valid[i] && (entries[i].line == miss_alloc_line)) begin
        merge_hit = 1'b1;
      end
    end
  end

  assign queue_full  = (ptr_t'(tail_ptr - wait_ptr) == ptr_t'(dcache_pkg::miss_queue_depth));
  assign have_unsent = (send_ptr != tail_ptr);
  assign alloc       = miss_alloc_valid && !merge_hit && !queue_full;

  ////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////
  assign mem_req.command = have_unsent ? mem_bus_pkg::bus_load : mem_bus_pkg::bus_none;
  assign mem_req.addr    = {entries[send_slot].line, {dcache_pkg::offset_bits{1'b0}}};

  assign accepted = have_unsent && (mem_resp.resp_tag != '0);

  // data comes back in order, so only the oldest entry can match
  assign retire = entry_valid[wait_slot] && entries[wait_slot].sent &&
                  (mem_resp.data_tag != '0) &&
                  (mem_resp.data_tag == entries[wait_slot].mem_tag);

  assign fill_valid       = retire;
  assign fill_line        = entries[wait_slot].line;
  assign fill_write_cache = entries[wait_slot].write_cache && !store_match[wait_slot];
  assign fill_data        = mem_resp.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      tail_ptr    <= '0;
      send_ptr    <= '0;
      wait_ptr    <= '0;
    end else begin
      if (alloc) begin
        entry_valid[tail_slot] <= 1'b1;
        tail_ptr               <= tail_ptr + 1'b1;
      end
      if (accepted) begin
        send_ptr <= send_ptr + 1'b1;
      end
      if (retire) begin
        entry_valid[wait_slot] <= 1'b0;
        wait_ptr               <= wait_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    // a store makes the pending fill stale
    for (int i = 0; i < dcache_pkg::miss_queue_depth; i++) begin
      if (store_match[i]) begin
        entries[i].write_cache <= 1'b0;
      end
    end
    if (accepted) begin
      entries[send_slot].mem_tag <= mem_resp.resp_tag;
      entries[send_slot].sent    <= 1'b1;
    end
    if (alloc) begin
      entries[tail_slot].line        <= miss_alloc_line;
      entries[tail_slot].mem_tag     <= '0;
      entries[tail_slot].sent        <= 1'b0;
      entries[tail_slot].write_cache <= !(store_valid && (store_line == miss_alloc_line));
    end
  end

endmodule

/* src/fill_result.sv */
`timescale 1ns/1ps

module fill_result (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             fill_valid,
  input  dcache_pkg::line_addr_t           fill_line,
  input  logic                             fill_write_cache,
  input  logic [dcache_pkg::data_bits-1:0] fill_data,
  output dcache_pkg::cache_write_t         fill_write,
  output dcache_pkg::miss_result_t         miss_result
);

  logic                             result_pending;
  dcache_pkg::line_addr_t           line_q;
  logic [dcache_pkg::data_bits-1:0] data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      result_pending <= 1'b0;
    end else begin
      result_pending <= fill_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_valid) begin
      line_q <= fill_line;
      data_q <= fill_data;
    end
  end

  // lands at the edge that opens the miss result cycle
  // skipped when a store already owns the line
  assign fill_write.en    = fill_valid && fill_write_cache;
  assign fill_write.index = fill_line[dcache_pkg::index_bits-1:0];
  assign fill_write.tag   = fill_line[dcache_pkg::index_bits +: dcache_pkg::tag_bits];
  assign fill_write.data  = fill_data;

  assign miss_result.valid = result_pending;
  assign miss_result.addr  = {line_q, {dcache_pkg::offset_bits{1'b0}}};
  assign miss_result.data  = data_q;

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
  input  logic                     clock,
  input  logic                     reset,
  input  dcache_pkg::rd_req_t      rd_req,
  input  dcache_pkg::wr_req_t      wr_req,
  input  mem_bus_pkg::mem_resp_t   mem_resp,
  output dcache_pkg::rd_result_t   rd_result,
  output dcache_pkg::miss_result_t miss_result,
  output mem_bus_pkg::mem_req_t    mem_req
);

  logic [dcache_pkg::index_bits-1:0] lookup_index;
  dcache_pkg::cache_line_t           lookup_line;
  logic                              miss_alloc_valid;
  dcache_pkg::line_addr_t            miss_alloc_line;
  logic                              store_valid;
  dcache_pkg::line_addr_t            store_line;
  dcache_pkg::cache_write_t          store_write;
  dcache_pkg::cache_write_t          fill_write;
  logic                              fill_valid;
  dcache_pkg::line_addr_t            fill_line;
  logic                              fill_write_cache;
  logic [dcache_pkg::data_bits-1:0]  fill_data;

  request_decode decode_i (
    .rd_req           (rd_req),
    .wr_req           (wr_req),
    .lookup_line      (lookup_line),
    .lookup_index     (lookup_index),
    .rd_result        (rd_result),
    .miss_alloc_valid (miss_alloc_valid),
    .miss_alloc_line  (miss_alloc_line),
    .store_valid      (store_valid),
    .store_line       (store_line),
    .store_write      (store_write)
  );

  cache_array array_i (
    .clock        (clock),
    .reset        (reset),
    .lookup_index (lookup_index),
    .fill_write   (fill_write),
    .store_write  (store_write),
    .lookup_line  (lookup_line)
  );

  miss_queue queue_i (
    .clock            (clock),
    .reset            (reset),
    .miss_alloc_valid (miss_alloc_valid),
    .miss_alloc_line  (miss_alloc_line),
    .store_valid      (store_valid),
    .store_line       (store_line),
    .mem_resp         (mem_resp),
    .mem_req          (mem_req),
    .fill_valid       (fill_valid),
    .fill_line        (fill_line),
    .fill_write_cache (fill_write_cache),
    .fill_data        (fill_data)
  );

  fill_result fill_i (
    .clock            (clock),
    .reset            (reset),
    .fill_valid       (fill_valid),
    .fill_line        (fill_line),
    .fill_write_cache (fill_write_cache),
    .fill_data        (fill_data),
    .fill_write       (fill_write),
    .miss_result      (miss_result)
  );

endmodule

/* testbench/dcache_assertions.sv */
`timescale 1ns/1ps

module dcache_assertions (
  input logic                     clock,
  input logic                     reset,
  input dcache_pkg::rd_req_t      rd_req,
  input dcache_pkg::rd_result_t   rd_result,
  input dcache_pkg::miss_result_t miss_result,
  input mem_bus_pkg::mem_req_t    mem_req
);

  // loads always fetch a whole line
  load_aligned: assert property (@(posedge clock) disable iff (reset)
    (mem_req.command == mem_bus_pkg::bus_load) |->
      (mem_req.addr[dcache_pkg::offset_bits-1:0] == '0))
    else $error("bus_load address has a nonzero line offset");

  hit_needs_request: assert property (@(posedge clock) disable iff (reset)
    rd_result.valid |-> rd_req.en)
    else $error("read result valid without a read request");

  miss_result_pulse: assert property (@(posedge clock) disable iff (reset)
    miss_result.valid |=> !miss_result.valid)
    else $error("miss result valid for two cycles in a row");

  // first edge of reset still sees the power-up state
  idle_in_reset: assert property (@(posedge clock)
    (reset && $past(reset)) |-> (mem_req.command == mem_bus_pkg::bus_none))
    else $error("bus command active while reset is held");

endmodule

bind dcache_top dcache_assertions assertions_i (
  .clock       (clock),
  .reset       (reset),
  .rd_req      (rd_req),
  .rd_result   (rd_result),
  .miss_result (miss_result),
  .mem_req     (mem_req)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

  typedef struct packed {
    logic [mem_bus_pkg::mem_tag_bits-1:0] tag;
    logic [dcache_pkg::addr_bits-1:0]     addr;
    int                                   due;
  } pending_load_t;

  logic                     clock;
  logic                     reset;
  dcache_pkg::rd_req_t      rd_req;
  dcache_pkg::wr_req_t      wr_req;
  mem_bus_pkg::mem_resp_t   mem_resp = '0;
  dcache_pkg::rd_result_t   rd_result;
  dcache_pkg::miss_result_t miss_result;
  mem_bus_pkg::mem_req_t    mem_req;

  int errors       = 0;
  int checks       = 0;
  int seed         = 32'hf761b2fe;
  int accept_odds  = 3;
  int reject_count = 0;
  int cycle        = 0;
  int roll;

  logic [mem_bus_pkg::mem_tag_bits-1:0] next_tag = 4'd1;
  logic                                 was_rejected = 1'b0;
  logic                                 returned_last = 1'b0;
  mem_bus_pkg::mem_req_t                last_offer;
  pending_load_t                        new_load;
  pending_load_t                        pending [$];
  mem_bus_pkg::mem_req_t                load_log [$];
  dcache_pkg::miss_result_t             got_misses [$];
  dcache_pkg::miss_result_t             exp_misses [$];

  dcache_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .mem_resp    (mem_resp),
    .rd_result   (rd_result),
    .miss_result (miss_result),
    .mem_req     (mem_req)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // six short tests of a few hundred cycles each, with a wide margin
  initial begin
    #20000;
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [63:0] model_word(input logic [31:0] addr);
    logic [31:0] product;
    product = addr * 32'h9e3779b1;
    return {32'h0, product};
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////
  always @(posedge clock) begin
    #1;
    cycle++;
    mem_resp = '0;
    if (was_rejected) begin
      compare_mem_req(mem_req, last_offer, "re-offered load");
    end
    was_rejected = 1'b0;
    if (mem_req.command == mem_bus_pkg::bus_load) begin
      roll = $random(seed);
      if ((roll & 3) < accept_odds) begin
        roll = $random(seed);
        new_load.tag  = next_tag;
        new_load.addr = mem_req.addr;
        new_load.due  = cycle + 2 + (roll & 7) % 5;
        pending.push_back(new_load);
        load_log.push_back(mem_req);
        mem_resp.resp_tag = next_tag;
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end else begin
        was_rejected = 1'b1;
        last_offer   = mem_req;
        reject_count++;
      end
    end
    // at most one return every other cycle
    if (!returned_last && pending.size() > 0 && pending[0].due <= cycle) begin
      mem_resp.data_tag = pending[0].tag;
      mem_resp.data     = model_word(pending[0].addr);
      void'(pending.pop_front());
      returned_last = 1'b1;
    end else begin
      returned_last = 1'b0;
    end
  end

  always @(posedge clock) begin
    #1;
    if (miss_result.valid === 1'b1) begin
      got_misses.push_back(miss_result);
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic compare_rd_result(input dcache_pkg::rd_result_t got,
                                   input dcache_pkg::rd_result_t exp, input string what);
    checks++;
    if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
      $display("mismatch at %0t: %s got valid %b data %h, expected valid %b data %h",
               $time, what, got.valid, got.data, exp.valid, exp.data);
      errors++;
    end
  endtask

  task automatic compare_miss_result(input dcache_pkg::miss_result_t got,
                                     input dcache_pkg::miss_result_t exp, input string what);
    checks++;
    if (got.valid !== exp.valid || (exp.valid && (got.addr !== exp.addr ||
        got.data !== exp.data))) begin
      $display("mismatch at %0t: %s got %b/%h/%h, expected %b/%h/%h", $time, what,
               got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data);
      errors++;
    end
  endtask

  task automatic compare_mem_req(input mem_bus_pkg::mem_req_t got,
                                 input mem_bus_pkg::mem_req_t exp, input string what);
    checks++;
    if (got.command !== exp.command ||
        (exp.command == mem_bus_pkg::bus_load && got.addr !== exp.addr)) begin
      $display("mismatch at %0t: %s got %s %h, expected %s %h", $time, what,
               got.command.name(), got.addr, exp.command.name(), exp.addr);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic read_and_check(input logic [31:0] addr, input logic hit,
                                input logic [63:0] data);
    dcache_pkg::rd_result_t exp;
    @(posedge clock);
    #1;
    wr_req.en   = 1'b0;
    rd_req.en   = 1'b1;
    rd_req.addr = addr;
    #2;
    exp.valid = hit;
    exp.data  = data;
    compare_rd_result(rd_result, exp, hit ? "read hit" : "read miss");
  endtask

  // a read in the cycle of the miss result must already hit
  task automatic read_during_fill(input logic [31:0] addr, input logic [63:0] data);
    dcache_pkg::rd_result_t exp;
    int                     waited;
    waited = 0;
    @(posedge clock);
    #1;
    rd_req.en = 1'b0;
    while (miss_result.valid !== 1'b1 && waited < 200) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (miss_result.valid !== 1'b1) begin
      $display("error at %0t: no miss result arrived for the read", $time);
      errors++;
    end else begin
      rd_req.en   = 1'b1;
      rd_req.addr = addr;
      #2;
      exp.valid = 1'b1;
      exp.data  = data;
      compare_rd_result(rd_result, exp, "read in the fill cycle");
    end
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [63:0] data);
    @(posedge clock);
    #1;
    rd_req.en   = 1'b0;
    wr_req.en   = 1'b1;
    wr_req.addr = addr;
    wr_req.data = data;
  endtask

  task automatic go_idle(input int cycles);
    @(posedge clock);
    #1;
    rd_req.en = 1'b0;
    wr_req.en = 1'b0;
    repeat (cycles) @(posedge clock);
  endtask

  task automatic expect_miss(input logic [31:0] addr);
    dcache_pkg::miss_result_t exp;
    exp.valid = 1'b1;
    exp.addr  = {addr[31:3], 3'b000};
    exp.data  = model_word(exp.addr);
    exp_misses.push_back(exp);
  endtask

  // waits for every expected miss result, then checks order and extras
  task automatic wait_misses();
    int waited;
    waited = 0;
    while (got_misses.size() < exp_misses.size() && waited < 200) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (got_misses.size() < exp_misses.size()) begin
      $display("error at %0t: miss results did not arrive in time", $time);
      errors++;
    end
    repeat (8) @(posedge clock);
    #2;
    while (exp_misses.size() > 0 && got_misses.size() > 0) begin
      compare_miss_result(got_misses.pop_front(), exp_misses.pop_front(), "miss result");
    end
    if (got_misses.size() != 0) begin
      $display("error at %0t: %0d unexpected miss results", $time, got_misses.size());
      errors++;
    end
    got_misses.delete();
    exp_misses.delete();
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_reset_state();
    mem_bus_pkg::mem_req_t    idle_req;
    dcache_pkg::rd_result_t   no_result;
    dcache_pkg::miss_result_t no_miss;
    idle_req.command = mem_bus_pkg::bus_none;
    idle_req.addr    = '0;
    no_result        = '0;
    no_miss          = '0;
    repeat (4) begin
      @(posedge clock);
      #2;
      compare_mem_req(mem_req, idle_req, "bus after reset");
      compare_rd_result(rd_result, no_result, "read result after reset");
      compare_miss_result(miss_result, no_miss, "miss result after reset");
    end
    read_and_check(32'h0000_1240, 1'b0, '0);
    expect_miss(32'h0000_1240);
    go_idle(1);
    wait_misses();
  endtask

  task automatic test_miss_and_fill();
    read_and_check(32'h0004_3a18, 1'b0, '0);
    expect_miss(32'h0004_3a18);
    read_during_fill(32'h0004_3a18, model_word(32'h0004_3a18));
    go_idle(1);
    wait_misses();
    read_and_check(32'h0004_3a18, 1'b1, model_word(32'h0004_3a18));
    go_idle(1);
  endtask

  task automatic test_store_then_load();
    load_log.delete();
    store_word(32'h0010_0058, 64'hdead_beef_0123_4567);
    read_and_check(32'h0010_0058, 1'b1, 64'hdead_beef_0123_4567);
    go_idle(8);
    foreach (load_log[i]) begin
      if (load_log[i].addr[31:3] == 29'(32'h0010_0058 >> 3)) begin
        $display("error at %0t: a load was issued for a stored line", $time);
        errors++;
      end
    end
  endtask

  task automatic test_back_pressure();
    accept_odds  = 1;
    reject_count = 0;
    read_and_check(32'h0020_0060, 1'b0, '0);
    read_and_check(32'h0020_0068, 1'b0, '0);
    read_and_check(32'h0020_0070, 1'b0, '0);
    expect_miss(32'h0020_0060);
    expect_miss(32'h0020_0068);
    expect_miss(32'h0020_0070);
    go_idle(1);
    wait_misses();
    accept_odds = 3;
    if (reject_count == 0) begin
      $display("error at %0t: the memory model never rejected a load", $time);
      errors++;
    end
    read_and_check(32'h0020_0068, 1'b1, model_word(32'h0020_0068));
    go_idle(1);
  endtask

  task automatic test_several_misses();
    logic [31:0]           lines [4];
    mem_bus_pkg::mem_req_t exp_load;
    lines = '{32'h0030_0080, 32'h0030_0088, 32'h0030_0090, 32'h0030_0098};
    load_log.delete();
    for (int i = 0; i < 3; i++) begin
      read_and_check(lines[i], 1'b0, '0);
      expect_miss(lines[i]);
    end
    // repeated line merges into the pending entry
    read_and_check(lines[0], 1'b0, '0);
    read_and_check(lines[3], 1'b0, '0);
    expect_miss(lines[3]);
    go_idle(1);
    wait_misses();
    if (load_log.size() != 4) begin
      $display("error at %0t: expected four loads but saw %0d", $time, load_log.size());
      errors++;
    end else begin
      for (int i = 0; i < 4; i++) begin
        exp_load.command = mem_bus_pkg::bus_load;
        exp_load.addr    = lines[i];
        compare_mem_req(load_log[i], exp_load, "load order");
      end
    end
  endtask

  task automatic test_store_during_miss();
    read_and_check(32'h0040_00a0, 1'b0, '0);
    store_word(32'h0040_00a0, 64'h5a5a_0f0f_c3c3_9696);
    expect_miss(32'h0040_00a0);
    go_idle(1);
    wait_misses();
    read_and_check(32'h0040_00a0, 1'b1, 64'h5a5a_0f0f_c3c3_9696);
    go_idle(1);
  endtask

  initial begin
    reset  = 1'b1;
    rd_req = '0;
    wr_req = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_miss_and_fill();
    test_store_then_load();
    test_back_pressure();
    test_several_misses();
    test_store_during_miss();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/request_decode.sv
src/cache_array.sv
src/miss_queue.sv
src/fill_result.sv
src/dcache_top.sv
testbench/dcache_assertions.sv
testbench/dcache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))
SIM     = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG) && grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
